// ==== proc_ci_pkg.sv ====
package proc_ci_pkg;

    // UART and boot timing
    localparam int CLKS_PER_BIT = 8;
    localparam int BOOT_CYCLES  = 16;

    // Word memory sizing
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = 6;

    localparam logic [7:0] HARNESS_ID = 8'hC1;

    // Host command bytes
    localparam logic [7:0] CMD_WRITE = 8'h01;
    localparam logic [7:0] CMD_READ  = 8'h02;
    localparam logic [7:0] CMD_RUN   = 8'h03;
    localparam logic [7:0] CMD_ID    = 8'h04;

    // Any opcode outside this set halts the core
    localparam logic [3:0] OP_HALT = 4'd0;
    localparam logic [3:0] OP_LDI  = 4'd1;
    localparam logic [3:0] OP_LD   = 4'd2;
    localparam logic [3:0] OP_ADD  = 4'd3;
    localparam logic [3:0] OP_ST   = 4'd4;

    // Word-addressed request from core to controller
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Immediate form used by LDI
    typedef struct packed {
        logic [3:0]  op;
        logic [27:0] imm;
    } imm_fmt_t;

    // Memory operand form used by LD, ADD and ST
    typedef struct packed {
        logic [3:0]          op;
        logic [27-MEM_AW:0]  unused;
        logic [MEM_AW-1:0]   addr;
    } mem_fmt_t;

    typedef union packed {
        imm_fmt_t imm_f;
        mem_fmt_t mem_f;
    } instr_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       rx_i,
    output logic [7:0] byte_o,
    output logic       valid_o
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state_q;
    logic sync1_q;
    logic sync2_q;
    logic prev_q;
    logic [$clog2(proc_ci_pkg::CLKS_PER_BIT)-1:0] cnt_q;
    logic [2:0] bit_q;
    logic [7:0] shift_q;
    logic tick;

    assign tick   = (cnt_q == proc_ci_pkg::CLKS_PER_BIT - 1);
    assign byte_o = shift_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= 1'b1;
            sync2_q <= 1'b1;
            prev_q  <= 1'b1;
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            sync1_q <= rx_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            valid_o <= 1'b0;
            cnt_q   <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    // Falling edge marks the start bit
                    if (prev_q && !sync2_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (cnt_q == proc_ci_pkg::CLKS_PER_BIT / 2 - 1) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= sync2_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    // Bad stop bit drops the frame
                    if (tick) begin
                        valid_o <= sync2_q;
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && tick) begin
            shift_q <= {sync2_q, shift_q[7:1]};
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic [7:0] byte_i,
    input  logic       start_i,
    output logic       busy_o,
    output logic       tx_o
);

    logic [9:0] shift_q;
    logic [3:0] bit_q;
    logic [$clog2(proc_ci_pkg::CLKS_PER_BIT)-1:0] cnt_q;

    // Line idles high through the shifted-in ones
    assign tx_o = shift_q[0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shift_q <= '1;
            bit_q   <= '0;
            cnt_q   <= '0;
            busy_o  <= 1'b0;
        end else if (!busy_o) begin
            if (start_i) begin
                shift_q <= {1'b1, byte_i, 1'b0};
                bit_q   <= '0;
                cnt_q   <= '0;
                busy_o  <= 1'b1;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == proc_ci_pkg::CLKS_PER_BIT - 1) begin
                cnt_q   <= '0;
                shift_q <= {1'b1, shift_q[9:1]};
                bit_q   <= bit_q + 1'b1;
                // Stop bit done after the tenth bit time
                if (bit_q == 4'd9) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n_i) start_i |-> !busy_o
    );

endmodule

// ==== reset_boot.sv ====
`timescale 1ns/1ns

module reset_boot (
    input  logic clk,
    input  logic arst_n_i,
    output logic rst_n_o
);

    logic [$clog2(proc_ci_pkg::BOOT_CYCLES + 1)-1:0] cnt_q;

    // Assert at once, release only on a clock edge after the count
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q   <= '0;
            rst_n_o <= 1'b0;
        end else begin
            if (cnt_q != proc_ci_pkg::BOOT_CYCLES) begin
                cnt_q <= cnt_q + 1'b1;
            end
            rst_n_o <= (cnt_q >= proc_ci_pkg::BOOT_CYCLES - 1);
        end
    end

    a_full_stretch: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $rose(rst_n_o) |-> (cnt_q == proc_ci_pkg::BOOT_CYCLES)
    );

endmodule

// ==== ci_controller.sv ====
`timescale 1ns/1ns

module ci_controller (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [7:0]            rx_byte_i,
    input  logic                  rx_valid_i,
    output logic [7:0]            tx_byte_o,
    output logic                  tx_start_o,
    input  logic                  tx_busy_i,
    output logic                  core_rst_n_o,
    input  proc_ci_pkg::bus_req_t core_req_i,
    output proc_ci_pkg::bus_rsp_t core_rsp_o,
    input  logic                  core_halt_i
);

    typedef enum logic [2:0] {ST_CMD, ST_ADDR, ST_DATA, ST_REPLY, ST_RUN} state_t;

    state_t state_q;
    logic [7:0] cmd_q;
    logic [proc_ci_pkg::MEM_AW-1:0] addr_q;
    logic [23:0] data_q;
    logic [1:0] byte_cnt_q;
    logic [31:0] reply_q;
    logic [2:0] reply_left_q;
    logic ack_q;
    logic [31:0] mem [proc_ci_pkg::MEM_WORDS];
    logic host_we;
    logic core_we;
    logic [proc_ci_pkg::MEM_AW-1:0] core_addr;

    assign host_we   = (state_q == ST_DATA) && rx_valid_i && (byte_cnt_q == 2'd3);
    assign core_addr = core_req_i.addr[proc_ci_pkg::MEM_AW-1:0];
    assign core_we   = ack_q && core_req_i.we;

    assign core_rsp_o.ack   = ack_q;
    assign core_rsp_o.rdata = mem[core_addr];

    // Host writes only happen while the core is held in reset
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[addr_q] <= {rx_byte_i, data_q};
        end else if (core_we) begin
            mem[core_addr] <= core_req_i.wdata;
        end
    end

    // First three data bytes arrive little-endian
    always_ff @(posedge clk) begin
        if (state_q == ST_DATA && rx_valid_i) begin
            data_q <= {rx_byte_i, data_q[23:8]};
        end
    end

    // Single-beat ack one cycle after stb is seen
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= core_rst_n_o && core_req_i.cyc && core_req_i.stb && !ack_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_CMD;
            cmd_q        <= '0;
            addr_q       <= '0;
            byte_cnt_q   <= '0;
            reply_q      <= '0;
            reply_left_q <= '0;
            tx_byte_o    <= '0;
            tx_start_o   <= 1'b0;
            core_rst_n_o <= 1'b0;
        end else begin
            tx_start_o <= 1'b0;
            case (state_q)
                ST_CMD: begin
                    if (rx_valid_i) begin
                        cmd_q <= rx_byte_i;
                        case (rx_byte_i)
                            proc_ci_pkg::CMD_WRITE, proc_ci_pkg::CMD_READ: begin
                                state_q <= ST_ADDR;
                            end
                            proc_ci_pkg::CMD_RUN: begin
                                core_rst_n_o <= 1'b1;
                                state_q      <= ST_RUN;
                            end
                            proc_ci_pkg::CMD_ID: begin
                                reply_q      <= {24'd0, proc_ci_pkg::HARNESS_ID};
                                reply_left_q <= 3'd1;
                                state_q      <= ST_REPLY;
                            end
                            // Unknown commands are silently dropped
                            default: ;
                        endcase
                    end
                end
                ST_ADDR: begin
                    if (rx_valid_i) begin
                        addr_q     <= rx_byte_i[proc_ci_pkg::MEM_AW-1:0];
                        byte_cnt_q <= '0;
                        if (cmd_q == proc_ci_pkg::CMD_WRITE) begin
                            state_q <= ST_DATA;
                        end else begin
                            reply_q      <= mem[rx_byte_i[proc_ci_pkg::MEM_AW-1:0]];
                            reply_left_q <= 3'd4;
                            state_q      <= ST_REPLY;
                        end
                    end
                end
                ST_DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'd3) begin
                            reply_q      <= {24'd0, proc_ci_pkg::CMD_WRITE};
                            reply_left_q <= 3'd1;
                            state_q      <= ST_REPLY;
                        end
                    end
                end
                ST_REPLY: begin
                    // busy only shows up the cycle after a start pulse
                    if (!tx_busy_i && !tx_start_o) begin
                        if (reply_left_q == 3'd0) begin
                            state_q <= ST_CMD;
                        end else begin
                            tx_start_o   <= 1'b1;
                            tx_byte_o    <= reply_q[7:0];
                            reply_q      <= reply_q >> 8;
                            reply_left_q <= reply_left_q - 1'b1;
                        end
                    end
                end
                default: begin
                    if (core_halt_i) begin
                        core_rst_n_o <= 1'b0;
                        reply_q      <= {24'd0, proc_ci_pkg::CMD_RUN};
                        reply_left_q <= 3'd1;
                        state_q      <= ST_REPLY;
                    end
                end
            endcase
        end
    end

    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i) core_rsp_o.ack |-> core_req_i.stb
    );

    a_quiet_in_reset: assert property (
        @(posedge clk) disable iff (!arst_n_i) !core_rst_n_o |-> !core_req_i.stb
    );

endmodule

// ==== acc_core.sv ====
`timescale 1ns/1ns

module acc_core (
    input  logic                  clk,
    input  logic                  rst_n_i,
    output proc_ci_pkg::bus_req_t bus_o,
    input  proc_ci_pkg::bus_rsp_t bus_i,
    output logic                  halt_o
);

    typedef enum logic [1:0] {C_FETCH, C_EXEC, C_DATA, C_HALT} core_state_t;

    core_state_t state_q;
    proc_ci_pkg::bus_req_t req_q;
    proc_ci_pkg::instr_t ir_q;
    logic [proc_ci_pkg::MEM_AW-1:0] pc_q;
    logic [31:0] acc_q;
    logic halt_q;

    assign bus_o  = req_q;
    assign halt_o = halt_q;

    // Latch the instruction word on the fetch ack
    always_ff @(posedge clk) begin
        if (state_q == C_FETCH && req_q.stb && bus_i.ack) begin
            ir_q <= bus_i.rdata;
        end
    end

    // Reset comes synchronously from the controller
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= C_FETCH;
            req_q   <= '0;
            pc_q    <= '0;
            acc_q   <= '0;
            halt_q  <= 1'b0;
        end else begin
            case (state_q)
                C_FETCH: begin
                    if (!req_q.stb) begin
                        req_q.cyc  <= 1'b1;
                        req_q.stb  <= 1'b1;
                        req_q.we   <= 1'b0;
                        req_q.addr <= {{(32 - proc_ci_pkg::MEM_AW){1'b0}}, pc_q};
                    end else if (bus_i.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state_q   <= C_EXEC;
                    end
                end
                C_EXEC: begin
                    case (ir_q.imm_f.op)
                        proc_ci_pkg::OP_LDI: begin
                            acc_q   <= {4'd0, ir_q.imm_f.imm};
                            pc_q    <= pc_q + 1'b1;
                            state_q <= C_FETCH;
                        end
                        proc_ci_pkg::OP_LD, proc_ci_pkg::OP_ADD, proc_ci_pkg::OP_ST: begin
                            state_q <= C_DATA;
                        end
                        // HALT and undefined opcodes
                        default: begin
                            halt_q  <= 1'b1;
                            state_q <= C_HALT;
                        end
                    endcase
                end
                C_DATA: begin
                    if (!req_q.stb) begin
                        req_q.cyc   <= 1'b1;
                        req_q.stb   <= 1'b1;
                        req_q.we    <= (ir_q.mem_f.op == proc_ci_pkg::OP_ST);
                        req_q.addr  <= {{(32 - proc_ci_pkg::MEM_AW){1'b0}}, ir_q.mem_f.addr};
                        req_q.wdata <= acc_q;
                    end else if (bus_i.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        if (ir_q.mem_f.op == proc_ci_pkg::OP_LD) begin
                            acc_q <= bus_i.rdata;
                        end else if (ir_q.mem_f.op == proc_ci_pkg::OP_ADD) begin
                            acc_q <= acc_q + bus_i.rdata;
                        end
                        pc_q    <= pc_q + 1'b1;
                        state_q <= C_FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (bus_o.stb && !bus_i.ack) |=> $stable(bus_o)
    );

endmodule

// ==== processorci_top.sv ====
`timescale 1ns/1ns

module processorci_top (
    input  logic clk,
    input  logic arst_n_i,
    input  logic rx_i,
    output logic tx_o
);

    logic sys_rst_n;
    logic [7:0] rx_byte;
    logic rx_valid;
    logic [7:0] tx_byte;
    logic tx_start;
    logic tx_busy;
    logic core_rst_n;
    logic core_halt;
    proc_ci_pkg::bus_req_t core_req;
    proc_ci_pkg::bus_rsp_t core_rsp;

    reset_boot i_reset_boot (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rst_n_o  (sys_rst_n)
    );

    uart_rx i_uart_rx (
        .clk      (clk),
        .arst_n_i (sys_rst_n),
        .rx_i     (rx_i),
        .byte_o   (rx_byte),
        .valid_o  (rx_valid)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .arst_n_i (sys_rst_n),
        .byte_i   (tx_byte),
        .start_i  (tx_start),
        .busy_o   (tx_busy),
        .tx_o     (tx_o)
    );

    ci_controller i_ci_controller (
        .clk          (clk),
        .arst_n_i     (sys_rst_n),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .tx_byte_o    (tx_byte),
        .tx_start_o   (tx_start),
        .tx_busy_i    (tx_busy),
        .core_rst_n_o (core_rst_n),
        .core_req_i   (core_req),
        .core_rsp_o   (core_rsp),
        .core_halt_i  (core_halt)
    );

    acc_core i_acc_core (
        .clk     (clk),
        .rst_n_i (core_rst_n),
        .bus_o   (core_req),
        .bus_i   (core_rsp),
        .halt_o  (core_halt)
    );

endmodule

// ==== tb_processorci.sv ====
`timescale 1ns/1ns

module tb_processorci;

    logic clk;
    logic arst_n_i;
    logic rx_i;
    logic tx_o;

    integer seed;
    int errors;
    logic [31:0] word;
    int addr;

    // Host-side copy of the harness memory
    logic [31:0] mirror [proc_ci_pkg::MEM_WORDS];

    // Timeouts in clk cycles
    int idle_window   = 200;
    int reply_timeout = 400;
    int run_timeout   = 3000;
    int step_limit    = 256;

    processorci_top i_dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    always #5 clk = ~clk;

    // One 8N1 frame on rx_i
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_i = frame[i];
            repeat (proc_ci_pkg::CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    // Start bit search with timeout, then mid-bit sampling
    task automatic recv_byte(input int timeout, output logic got_o, output logic [7:0] b_o);
        int waited;
        got_o  = 1'b0;
        b_o    = '0;
        waited = 0;
        while (tx_o !== 1'b0 && waited < timeout) begin
            @(negedge clk);
            waited++;
        end
        if (tx_o === 1'b0) begin
            repeat (proc_ci_pkg::CLKS_PER_BIT / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (proc_ci_pkg::CLKS_PER_BIT) @(negedge clk);
                b_o[i] = tx_o;
            end
            repeat (proc_ci_pkg::CLKS_PER_BIT) @(negedge clk);
            got_o = 1'b1;
            assert (tx_o === 1'b1) else begin
                errors++;
                $display("stop bit on tx_o was not high");
            end
        end
    endtask

    // tx_o must read high on every cycle of the window
    task automatic watch_idle_line(input string name, input int cycles);
        logic idle;
        idle = 1'b1;
        for (int i = 0; i < cycles && idle; i++) begin
            @(negedge clk);
            idle = (tx_o === 1'b1);
        end
        assert (idle) else begin
            errors++;
            $display("%s: tx_o left the idle high level", name);
        end
    endtask

    task automatic expect_byte(input string name, input logic [7:0] exp, input int timeout);
        logic got_b;
        logic [7:0] b;
        recv_byte(timeout, got_b, b);
        assert (got_b) else begin
            errors++;
            $display("%s: no reply byte arrived on tx_o before the timeout", name);
        end
        if (got_b) begin
            assert (b === exp) else begin
                errors++;
                $display("mismatch %s: expected %h actual %h", name, exp, b);
            end
        end
    endtask

    task automatic host_write(input int a, input logic [31:0] data);
        send_byte(proc_ci_pkg::CMD_WRITE);
        send_byte(8'(a));
        for (int i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8]);
        end
        mirror[a] = data;
        expect_byte("write_ack", 8'h01, reply_timeout);
    endtask

    // READ a word and compare against the little-endian reply
    task automatic check_word(input string name, input int a, input logic [31:0] exp);
        logic got_b;
        logic ok;
        logic [7:0] b;
        logic [31:0] w;
        ok = 1'b1;
        w  = '0;
        send_byte(proc_ci_pkg::CMD_READ);
        send_byte(8'(a));
        for (int i = 0; i < 4; i++) begin
            recv_byte(reply_timeout, got_b, b);
            ok = ok & got_b;
            w[8*i +: 8] = b;
        end
        assert (ok) else begin
            errors++;
            $display("%s: read of word %0d got no complete reply", name, a);
        end
        if (ok) begin
            assert (w === exp) else begin
                errors++;
                $display("mismatch %s word %0d: expected %h actual %h", name, a, exp, w);
            end
        end
    endtask

    // Reference execution of the program held in the mirror
    task automatic run_model();
        logic [proc_ci_pkg::MEM_AW-1:0] pc;
        logic [31:0] acc;
        logic [31:0] w;
        logic halted;
        pc     = '0;
        acc    = '0;
        halted = 1'b0;
        for (int n = 0; n < step_limit && !halted; n++) begin
            w = mirror[pc];
            case (w[31:28])
                proc_ci_pkg::OP_LDI: acc = {4'd0, w[27:0]};
                proc_ci_pkg::OP_LD:  acc = mirror[w[proc_ci_pkg::MEM_AW-1:0]];
                proc_ci_pkg::OP_ADD: acc = acc + mirror[w[proc_ci_pkg::MEM_AW-1:0]];
                proc_ci_pkg::OP_ST:  mirror[w[proc_ci_pkg::MEM_AW-1:0]] = acc;
                default:             halted = 1'b1;
            endcase
            if (!halted) begin
                pc = pc + 1'b1;
            end
        end
        assert (halted) else begin
            errors++;
            $display("core model did not halt within the instruction limit");
        end
    endtask

    // 4 to 12 random instructions, operands in the upper half, then HALT
    task automatic load_program(input logic store_first);
        proc_ci_pkg::instr_t ins;
        int n;
        int sel;
        n = 4 + {$random(seed)} % 9;
        for (int i = 0; i <= n; i++) begin
            ins = '0;
            sel = {$random(seed)} % 4;
            if (i == 0 && store_first) begin
                sel = 3;
            end
            if (i == n) begin
                ins.imm_f.op = proc_ci_pkg::OP_HALT;
            end else if (sel == 0) begin
                ins.imm_f.op  = proc_ci_pkg::OP_LDI;
                ins.imm_f.imm = 28'($random(seed));
            end else begin
                case (sel)
                    1:       ins.mem_f.op = proc_ci_pkg::OP_LD;
                    2:       ins.mem_f.op = proc_ci_pkg::OP_ADD;
                    default: ins.mem_f.op = proc_ci_pkg::OP_ST;
                endcase
                ins.mem_f.addr = 6'(32 + {$random(seed)} % 32);
            end
            host_write(i, ins);
        end
    endtask

    task automatic run_and_check(input string name, input logic store_first);
        load_program(store_first);
        send_byte(proc_ci_pkg::CMD_RUN);
        expect_byte(name, 8'h03, run_timeout);
        run_model();
        for (int a = 32; a < 64; a++) begin
            check_word(name, a, mirror[a]);
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n_i = 1'b0;
        rx_i     = 1'b1;
        seed     = 54601;
        errors   = 0;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;

        // Line must stay idle through the boot stretch
        watch_idle_line("idle_after_reset", idle_window);
        send_byte(proc_ci_pkg::CMD_ID);
        expect_byte("id_after_reset", 8'hC1, reply_timeout);

        for (int n = 0; n < 8; n++) begin
            addr = {$random(seed)} % proc_ci_pkg::MEM_WORDS;
            word = $random(seed);
            host_write(addr, word);
            check_word("write_read", addr, word);
        end

        // Operand area
        for (int a = 32; a < 64; a++) begin
            host_write(a, $random(seed));
        end
        run_and_check("run1", 1'b0);
        // Leading store exposes the accumulator value after reset
        run_and_check("run2", 1'b1);

        // Command bytes above 0x04 have no meaning
        send_byte(8'(5 + {$random(seed)} % 251));
        watch_idle_line("unknown_cmd", idle_window);
        send_byte(proc_ci_pkg::CMD_ID);
        expect_byte("id_after_unknown", 8'hC1, reply_timeout);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
proc_ci_pkg.sv
uart_rx.sv
uart_tx.sv
reset_boot.sv
ci_controller.sv
acc_core.sv
processorci_top.sv
tb_processorci.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_processorci
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" \
    -Mdir obj_dir -o "$TOP" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
